// File: design/spr_cfg_params.svh
`ifndef SPR_CFG_PARAMS_SVH
`define SPR_CFG_PARAMS_SVH

// synthesis-time feature switches.
`define DCACHE_EN          1
`define DCACHE_WAYS        2
`define DCACHE_SET_WIDTH   9
`define DCACHE_BLOCK_WIDTH 5  // 5 means 32-byte blocks.
`define ICACHE_EN          1
`define ICACHE_WAYS        4
`define ICACHE_SET_WIDTH   8
`define ICACHE_BLOCK_WIDTH 4  // 4 means 16-byte blocks.
`define PIC_EN             1
`define TIMER_EN           1

// spr address split.
`define SPR_WORD_W 32
`define SPR_ADDR_W 16
`define SPR_GRP_W  5  // upper address bits.
`define SPR_IDX_W  11 // lower address bits.

// group 0 register indices.
`define SPR_IDX_VR       11'd0
`define SPR_IDX_UPR      11'd1
`define SPR_IDX_CPUCFGR  11'd2
`define SPR_IDX_DMMUCFGR 11'd3
`define SPR_IDX_IMMUCFGR 11'd4
`define SPR_IDX_DCCFGR   11'd5
`define SPR_IDX_ICCFGR   11'd6
`define SPR_IDX_DCFGR    11'd7
`define SPR_IDX_PCCFGR   11'd8
`define SPR_IDX_FPCSR    11'd20 // only writable one.

// upr present bits.
`define SPR_UPR_UP   0
`define SPR_UPR_DCP  1
`define SPR_UPR_ICP  2
`define SPR_UPR_PICP 8
`define SPR_UPR_TTP  10

`define SPR_CPUCFGR_OB32S 5 // 32-bit basic set.

// dccfgr and iccfgr share the low fields.
`define SPR_CCFGR_NCW   2:0
`define SPR_CCFGR_NCS   6:3
`define SPR_CCFGR_CBS   7
`define SPR_CCFGR_CBIRI 10
`define SPR_DCCFGR_CBFRI 13 // dcache only.

`endif

// File: design/spr_cfg_pkg.sv
`include "spr_cfg_params.svh"

package spr_cfg_pkg;

  // meaningful widths.
  typedef logic [`SPR_WORD_W-1:0] spr_word_t; // one spr data word.
  typedef logic [`SPR_ADDR_W-1:0] spr_addr_t; // group and index.
  typedef logic [`SPR_GRP_W-1:0]  spr_grp_t;  // group number.
  typedef logic [`SPR_IDX_W-1:0]  spr_idx_t;  // index in group.

  // one access, 49 bits.
  typedef struct packed {
    logic      we;    // write when set.
    spr_addr_t addr;  // target spr.
    spr_word_t wdata; // write payload.
  } spr_req_t;

  // one answer, 33 bits.
  typedef struct packed {
    spr_word_t rdata; // zero on writes and errors.
    logic      err;   // unmapped or read-only write.
  } spr_rsp_t;

  // read-only group 0 words, 288 bits.
  typedef struct packed {
    spr_word_t vr;       // version.
    spr_word_t upr;      // unit present.
    spr_word_t cpucfgr;  // cpu config.
    spr_word_t dmmucfgr; // data mmu.
    spr_word_t immucfgr; // insn mmu.
    spr_word_t dccfgr;   // data cache.
    spr_word_t iccfgr;   // insn cache.
    spr_word_t dcfgr;    // debug.
    spr_word_t pccfgr;   // perf counters.
  } spr_cfg_bus_t;

endpackage

// File: design/or1k_cfg_regs.sv
`timescale 1ns/1ps
`include "spr_cfg_params.svh"

module or1k_cfg_regs #(
  parameter int dcache_en          = `DCACHE_EN,
  parameter int dcache_ways        = `DCACHE_WAYS,
  parameter int dcache_set_width   = `DCACHE_SET_WIDTH,
  parameter int dcache_block_width = `DCACHE_BLOCK_WIDTH,
  parameter int icache_en          = `ICACHE_EN,
  parameter int icache_ways        = `ICACHE_WAYS,
  parameter int icache_set_width   = `ICACHE_SET_WIDTH,
  parameter int icache_block_width = `ICACHE_BLOCK_WIDTH,
  parameter int pic_en             = `PIC_EN,
  parameter int timer_en           = `TIMER_EN
) (
  output spr_cfg_pkg::spr_cfg_bus_t cfg // constant words, no clock.
);

  // log2 of the way count, 1..32 ways.
  function automatic logic [2:0] ways_code(input int ways);
    logic [2:0] code;
    case (ways)
      1:       code = 3'd0;
      2:       code = 3'd1;
      4:       code = 3'd2;
      8:       code = 3'd3;
      16:      code = 3'd4;
      32:      code = 3'd5;
      default: code = 3'd0; // unsupported count.
    endcase
    return code;
  endfunction

  spr_cfg_pkg::spr_word_t upr;     // unit present.
  spr_cfg_pkg::spr_word_t cpucfgr; // cpu capabilities.
  spr_cfg_pkg::spr_word_t dccfgr;  // data cache geometry.
  spr_cfg_pkg::spr_word_t iccfgr;  // insn cache geometry.

  // upr from the present flags.
  always_comb begin
    upr                  = '0;
    upr[`SPR_UPR_UP]     = 1'b1;                 // upr itself present.
    upr[`SPR_UPR_DCP]    = (dcache_en != 0);     // data cache.
    upr[`SPR_UPR_ICP]    = (icache_en != 0);     // insn cache.
    upr[`SPR_UPR_PICP]   = (pic_en != 0);        // interrupt ctrl.
    upr[`SPR_UPR_TTP]    = (timer_en != 0);      // tick timer.
  end

  // orbis32 only, no float or vector sets.
  always_comb begin
    cpucfgr                     = '0;
    cpucfgr[`SPR_CPUCFGR_OB32S] = 1'b1;
  end

  // data cache word.
  always_comb begin
    dccfgr = '0;
    if (dcache_en != 0) begin
      dccfgr[`SPR_CCFGR_NCW]    = ways_code(dcache_ways);   // ways as log2.
      dccfgr[`SPR_CCFGR_NCS]    = 4'(dcache_set_width);     // sets as log2.
      dccfgr[`SPR_CCFGR_CBS]    = (dcache_block_width == 5); // 32-byte blocks.
      dccfgr[`SPR_CCFGR_CBIRI]  = 1'b1;                     // invalidate reg.
      dccfgr[`SPR_DCCFGR_CBFRI] = 1'b1;                     // flush reg.
    end
  end

  // insn cache word, no flush register there.
  always_comb begin
    iccfgr = '0;
    if (icache_en != 0) begin
      iccfgr[`SPR_CCFGR_NCW]   = ways_code(icache_ways);
      iccfgr[`SPR_CCFGR_NCS]   = 4'(icache_set_width);
      iccfgr[`SPR_CCFGR_CBS]   = (icache_block_width == 5);
      iccfgr[`SPR_CCFGR_CBIRI] = 1'b1;
    end
  end

  // pack the bus, unused units read zero.
  assign cfg = '{
    vr:       '0,       // no version info.
    upr:      upr,
    cpucfgr:  cpucfgr,
    dmmucfgr: '0,       // no data mmu.
    immucfgr: '0,       // no insn mmu.
    dccfgr:   dccfgr,
    iccfgr:   iccfgr,
    dcfgr:    '0,       // no debug unit.
    pccfgr:   '0        // no perf counters.
  };

endmodule

// File: design/spr_cfg_port.sv
`timescale 1ns/1ps
`include "spr_cfg_params.svh"

module spr_cfg_port (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      req_valid,
  input  spr_cfg_pkg::spr_req_t     req,
  output logic                      req_ready,
  output logic                      rsp_valid,
  output spr_cfg_pkg::spr_rsp_t     rsp,
  input  logic                      rsp_ready,
  input  spr_cfg_pkg::spr_cfg_bus_t cfg
);

  spr_cfg_pkg::spr_grp_t  req_grp;  // address group.
  spr_cfg_pkg::spr_idx_t  req_idx;  // address index.
  spr_cfg_pkg::spr_word_t sel_data; // selected read word.
  spr_cfg_pkg::spr_word_t fpcsr;    // fp control/status storage.
  spr_cfg_pkg::spr_rsp_t  rsp_d;    // next response.
  logic                   mapped;   // known group 0 reg.
  logic                   is_fpcsr; // targets fpcsr.
  logic                   accept;   // request handshake.

  assign req_grp = req.addr[`SPR_ADDR_W-1:`SPR_IDX_W];
  assign req_idx = req.addr[`SPR_IDX_W-1:0];

  // free slot, or the held response leaves now.
  assign req_ready = !rsp_valid || rsp_ready;
  assign accept    = req_valid && req_ready;

  // read mux over group 0.
  always_comb begin
    sel_data = '0;
    mapped   = 1'b1;
    case (req_idx)
      `SPR_IDX_VR:       sel_data = cfg.vr;
      `SPR_IDX_UPR:      sel_data = cfg.upr;
      `SPR_IDX_CPUCFGR:  sel_data = cfg.cpucfgr;
      `SPR_IDX_DMMUCFGR: sel_data = cfg.dmmucfgr;
      `SPR_IDX_IMMUCFGR: sel_data = cfg.immucfgr;
      `SPR_IDX_DCCFGR:   sel_data = cfg.dccfgr;
      `SPR_IDX_ICCFGR:   sel_data = cfg.iccfgr;
      `SPR_IDX_DCFGR:    sel_data = cfg.dcfgr;
      `SPR_IDX_PCCFGR:   sel_data = cfg.pccfgr;
      `SPR_IDX_FPCSR:    sel_data = fpcsr;
      default:           mapped   = 1'b0; // hole in the map.
    endcase
    if (req_grp != '0) begin
      mapped = 1'b0; // other groups absent.
    end
  end

  assign is_fpcsr = (req_grp == '0) && (req_idx == `SPR_IDX_FPCSR);

  // writes answer zero, errors answer zero.
  always_comb begin
    rsp_d.err   = !mapped || (req.we && !is_fpcsr);
    rsp_d.rdata = (rsp_d.err || req.we) ? '0 : sel_data;
  end

  // fpcsr, written at the accepting edge.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fpcsr <= '0;
    end else if (accept && req.we && is_fpcsr) begin
      fpcsr <= req.wdata;
    end
  end

  // one-entry response slot.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0; // drained, nothing new.
    end
  end

  // payload only loads on accept.
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp <= rsp_d;
    end
  end

  // stalled response must not move or vanish.
  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

  // no x on the handshake once out of reset.
  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(rsp_valid));

endmodule

// File: design/spr_cfg_top.sv
`timescale 1ns/1ps
`include "spr_cfg_params.svh"

module spr_cfg_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  req_valid,
  input  spr_cfg_pkg::spr_req_t req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output spr_cfg_pkg::spr_rsp_t rsp,
  input  logic                  rsp_ready
);

  spr_cfg_pkg::spr_cfg_bus_t cfg; // constant config words.

  // read-only words from the feature macros.
  or1k_cfg_regs #(
    .dcache_en          (`DCACHE_EN),
    .dcache_ways        (`DCACHE_WAYS),
    .dcache_set_width   (`DCACHE_SET_WIDTH),
    .dcache_block_width (`DCACHE_BLOCK_WIDTH),
    .icache_en          (`ICACHE_EN),
    .icache_ways        (`ICACHE_WAYS),
    .icache_set_width   (`ICACHE_SET_WIDTH),
    .icache_block_width (`ICACHE_BLOCK_WIDTH),
    .pic_en             (`PIC_EN),
    .timer_en           (`TIMER_EN)
  ) u_cfg_regs (
    .cfg (cfg)
  );

  // access port with fpcsr.
  spr_cfg_port u_port (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .cfg       (cfg)
  );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns = 4 // full period.
) (
  output logic clk
);

  initial begin
    clk = 1'b0; // known level before the first toggle.
  end

  always begin
    #(period_ns / 2) clk = ~clk; // half period per phase.
  end

endmodule

// File: dv/spr_cfg_tb.sv
`timescale 1ns/1ps

module spr_cfg_tb;

  localparam int timeout_cycles = 50; // per wait loop.

  // one golden access with its expected answer.
  typedef struct packed {
    logic [3:0]             op;    // bit0 write, bit1 no idle gap.
    spr_cfg_pkg::spr_addr_t addr;
    spr_cfg_pkg::spr_word_t wdata;
    spr_cfg_pkg::spr_word_t rdata; // expected data.
    logic                   err;   // expected flag.
    int                     stall; // cycles rsp_ready stays low.
  } vec_t;

  logic                  clk;
  logic                  arst_n;
  logic                  req_valid;
  spr_cfg_pkg::spr_req_t req;
  logic                  req_ready;
  logic                  rsp_valid;
  spr_cfg_pkg::spr_rsp_t rsp;
  logic                  rsp_ready;

  vec_t                  gold[$];  // all accesses from the file.
  vec_t                  exp_q[$]; // accepted, answer pending.
  vec_t                  cur;      // front of exp_q.
  int                    held;     // stalled cycles of the front.
  int                    late;     // cycles without rsp_valid.
  int                    rsp_cnt;  // responses consumed.
  logic                  mon_on;   // set once reset is released.

  tb_clk_gen #(.period_ns(4)) u_clk (.clk(clk));

  spr_cfg_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
                          $time, what, actual, expected));
    end
  endtask

  // columns are op, addr, wdata, rdata, err, stall in hex.
  task automatic load_golden();
    int                     fd;
    int                     nf;
    string                  line;
    logic [3:0]             op;
    spr_cfg_pkg::spr_addr_t addr;
    spr_cfg_pkg::spr_word_t wdata;
    spr_cfg_pkg::spr_word_t rdata;
    logic                   err;
    int                     stall;
    vec_t                   v;
    fd = $fopen("dv/spr_cfg_golden.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the golden file dv/spr_cfg_golden.txt");
    end
    while ($fgets(line, fd) != 0) begin
      nf = $sscanf(line, "%h %h %h %h %h %h", op, addr, wdata, rdata, err, stall);
      if (nf == 6) begin // comment and blank lines parse short.
        v.op    = op;
        v.addr  = addr;
        v.wdata = wdata;
        v.rdata = rdata;
        v.err   = err;
        v.stall = stall;
        gold.push_back(v);
      end
    end
    $fclose(fd);
    if (gold.size() == 0) begin
      abort_run("the golden file holds no accesses");
    end
  endtask

  // response side drives rsp_ready and checks every sampled cycle.
  always @(negedge clk) begin
    if (mon_on) begin
      if (exp_q.size() == 0) begin
        rsp_ready = 1'b1;
        #1;
        if (rsp_valid) begin
          abort_run("a response arrived with no request outstanding");
        end
        check_eq(64'(req_ready), 64'd1, "req_ready with the slot empty");
      end else begin
        cur       = exp_q[0];
        rsp_ready = (held >= cur.stall); // low for the first stall cycles.
        #1;
        if (!rsp_valid) begin
          late++;
          if (late >= timeout_cycles) begin
            abort_run("timed out waiting for rsp_valid");
          end
        end else begin
          check_eq(64'(late), 64'd0, "cycles from accept to rsp_valid");
          check_eq(64'(rsp.rdata), 64'(cur.rdata), $sformatf("rdata, addr 0x%04h", cur.addr));
          check_eq(64'(rsp.err), 64'(cur.err), $sformatf("err, addr 0x%04h", cur.addr));
          check_eq(64'(req_ready), 64'(rsp_ready), "req_ready with a response held");
          if (rsp_ready) begin
            exp_q.delete(0); // leaves at the next edge.
            held = 0;
            late = 0;
            rsp_cnt++;
          end else begin
            held++;
          end
        end
      end
    end
  end

  initial begin : main_seq
    int   idle;
    int   n;
    vec_t v;
    void'($urandom(91));
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    mon_on    = 1'b0;
    held      = 0;
    late      = 0;
    rsp_cnt   = 0;
    load_golden();
    repeat (8) @(negedge clk); // reset for 8 cycles.
    arst_n = 1'b1;
    mon_on = 1'b1;
    foreach (gold[i]) begin
      v = gold[i];
      if (!v.op[1]) begin
        idle = $urandom_range(2, 0);
        repeat (idle) @(negedge clk); // random gap.
      end
      req_valid = 1'b1;
      req.we    = v.op[0];
      req.addr  = v.addr;
      req.wdata = v.wdata;
      n = 0;
      #1;
      while (!req_ready) begin // request held while stalled.
        @(negedge clk);
        #1;
        n++;
        if (n >= timeout_cycles) begin
          abort_run($sformatf("timed out waiting for req_ready, access %0d", i));
        end
      end
      exp_q.push_back(v); // accepted at the coming edge.
      @(negedge clk);
      req_valid = 1'b0;
    end
    n = 0;
    while (rsp_cnt < gold.size()) begin
      @(negedge clk);
      n++;
      if (n >= timeout_cycles) begin
        abort_run("timed out waiting for the last responses");
      end
    end
    repeat (3) @(negedge clk); // room for a stray response.
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: dv/spr_cfg_golden.txt
# op addr wdata exp_rdata exp_err stall, all hex, one access per line
# op bit0 = write, op bit1 = issue with no idle gap after the previous access
0 0000 00000000 00000000 0 0
0 0001 00000000 00000507 0 0
2 0002 00000000 00000020 0 0
2 0005 00000000 000024c9 0 0
2 0006 00000000 00000442 0 0
0 0014 00000000 00000000 0 0
1 0014 a5a5f00d 00000000 0 0
2 0014 00000000 a5a5f00d 0 0
3 0014 0000001f 00000000 0 1
2 0014 00000000 0000001f 0 0
1 0001 ffffffff 00000000 1 0
2 0001 00000000 00000507 0 2
0 0009 00000000 00000000 1 0
2 0013 00000000 00000000 1 0
0 0800 00000000 00000000 1 0
2 1801 00000000 00000000 1 1
1 0009 12345678 00000000 1 0
0 0003 00000000 00000000 0 3
2 0004 00000000 00000000 0 3
2 0007 00000000 00000000 0 1
2 0008 00000000 00000000 0 0
1 0005 00000001 00000000 1 2
2 0005 00000000 000024c9 0 0
0 0002 00000000 00000020 0 0
3 0814 deadbeef 00000000 1 0
2 0014 00000000 0000001f 0 0

// File: all.f
+incdir+design
design/spr_cfg_pkg.sv
design/or1k_cfg_regs.sv
design/spr_cfg_port.sv
design/spr_cfg_top.sv
dv/tb_clk_gen.sv
dv/spr_cfg_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPR port testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module spr_cfg_tb -f all.f --Mdir obj_dir -o sim_spr_cfg
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_spr_cfg 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^TEST PASSED$'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
